// File: dv/link_exerciser_chk.sv
/*
 Concurrent checks on the top-level stream and PHY reset ports.
 Bound into every instance of link_exerciser_top.
*/
`timescale 1ns/1ps
`default_nettype none

module link_exerciser_chk #(
   parameter int DATA_W = 64
) (
   input wire logic              FCLK,
   input wire logic              ARSTn,
   input wire logic [DATA_W-1:0] tx_tdata,
   input wire logic              tx_tvalid,
   input wire logic              tx_tready,
   input wire logic              rx_tready,
   input wire logic              phy_rst_n
);

   // A stalled word may only change once valid has dropped
   a_tx_hold: assert property (@(posedge FCLK) disable iff (!ARSTn)
      (tx_tvalid && !tx_tready) |=> (!tx_tvalid || $stable(tx_tdata)))
      else $error("tx_tdata changed while stalled");

   a_tx_idle_in_reset: assert property (@(posedge FCLK) disable iff (!ARSTn)
      !phy_rst_n |-> !tx_tvalid)
      else $error("tx_tvalid high while phy_rst_n is low");

   // Covers both the board reset and the PHY reset window
   a_rx_idle_in_reset: assert property (@(posedge FCLK)
      (!ARSTn || !phy_rst_n) |-> !rx_tready)
      else $error("rx_tready high during reset");

endmodule

bind link_exerciser_top link_exerciser_chk #(
   .DATA_W(DATA_W)
) link_exerciser_chk_i (
   .FCLK     (FCLK),
   .ARSTn    (ARSTn),
   .tx_tdata (tx_tdata),
   .tx_tvalid(tx_tvalid),
   .tx_tready(tx_tready),
   .rx_tready(rx_tready),
   .phy_rst_n(phy_rst_n)
);

`default_nettype wire

// File: dv/link_exerciser_tb.sv
/*
 Testbench with a PHY model that loops TX back to RX two cycles later and
 can corrupt one returned word per table row. Bounded by a cycle watchdog.
*/
`timescale 1ns/1ps
`default_nettype none

module link_exerciser_tb;

   localparam int DATA_W     = 64;
   localparam int RST_CYCLES = 16;
   localparam int ERRCNT_W   = 16;
   localparam int NROWS      = 10;

   localparam logic [3:0] LINK_UP   = link_exerciser_pkg::STATUS_LINK_UP;
   localparam logic [3:0] LINK_DOWN = 4'd2;
   localparam logic [3:0] NO_ERR    = link_exerciser_pkg::ECODE_NONE;

   typedef struct {
      logic [3:0]        status;
      logic [3:0]        ecode;
      int                words;
      int                cidx;
      logic [DATA_W-1:0] mask;
      bit                restart;
      bit                exp_err;
      int                exp_cnt;
   } row_t;

   logic                FCLK      = 1'b0;
   logic                ARSTn     = 1'b0;
   logic                restart   = 1'b0;
   logic                tx_tready = 1'b0;
   logic [DATA_W-1:0]   rx_tdata  = '0;
   logic                rx_tvalid = 1'b0;
   logic [3:0]          status    = LINK_DOWN;
   logic [3:0]          ecode     = NO_ERR;
   logic [DATA_W-1:0]   tx_tdata;
   logic                tx_tvalid;
   logic                rx_tready;
   logic                phy_rst_n;
   logic                data_err;
   logic [ERRCNT_W-1:0] err_count;
   logic [1:0]          led;

   row_t              rows [NROWS];
   int                errors       = 0;
   int                checks       = 0;
   integer            seed         = 32;
   int                cycle        = 0;
   int                rx_total     = 0;
   int                corrupt_at   = -1;
   logic [DATA_W-1:0] corrupt_mask = '0;
   bit                table_ready  = 1'b0;
   logic [DATA_W-1:0] tx_q [$];
   int                tx_stamp [$];
   logic [DATA_W-1:0] tx_expect    = '0;
   logic [DATA_W-1:0] stall_word   = '0;
   bit                stall_q      = 1'b0;

   link_exerciser_top #(
      .DATA_W    (DATA_W),
      .RST_CYCLES(RST_CYCLES),
      .ERRCNT_W  (ERRCNT_W)
   ) link_exerciser_top_i (
      .FCLK     (FCLK),
      .ARSTn    (ARSTn),
      .restart  (restart),
      .tx_tdata (tx_tdata),
      .tx_tvalid(tx_tvalid),
      .tx_tready(tx_tready),
      .rx_tdata (rx_tdata),
      .rx_tvalid(rx_tvalid),
      .rx_tready(rx_tready),
      .status   (status),
      .ecode    (ecode),
      .phy_rst_n(phy_rst_n),
      .data_err (data_err),
      .err_count(err_count),
      .led      (led)
   );

   initial begin
      forever #10 FCLK = ~FCLK;
   end

   task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
      end
   endtask

   // PHY model: TX scoreboard, loopback queue and random TX back-pressure
   always @(posedge FCLK) begin
      tx_tready <= ($random(seed) & 3) != 0;
      if (!phy_rst_n) begin
         tx_q.delete();
         tx_stamp.delete();
         tx_expect = '0;
         stall_q   = 1'b0;
      end else begin
         if (stall_q && tx_tvalid) begin
            compare("tx_tdata hold", tx_tdata, stall_word);
         end
         stall_q    = tx_tvalid && !tx_tready;
         stall_word = tx_tdata;
         if (tx_tvalid && tx_tready) begin
            compare("tx_tdata", tx_tdata, tx_expect);
            tx_q.push_back(tx_tdata);
            tx_stamp.push_back(cycle);
            tx_expect++;
         end
         if (rx_tvalid && rx_tready) begin
            tx_q.delete(0);
            tx_stamp.delete(0);
            rx_total++;
         end
      end
      // Head word is held until RX accepts it
      if (tx_q.size() > 0 && cycle - tx_stamp[0] >= 1) begin
         rx_tvalid <= 1'b1;
         rx_tdata  <= tx_q[0] ^ ((rx_total == corrupt_at) ? corrupt_mask : '0);
      end else begin
         rx_tvalid <= 1'b0;
      end
      cycle++;
   end

   task automatic load_table();
      // status, ecode, words, corrupt index, mask, restart, data_err, err_count
      rows[0] = '{LINK_DOWN, NO_ERR, 0, 0, 64'h0, 1'b0, 1'b0, 0};
      rows[1] = '{LINK_UP, NO_ERR, 40, 0, 64'h0, 1'b0, 1'b0, 0};
      rows[2] = '{LINK_UP, NO_ERR, 30, 5, 64'h10, 1'b0, 1'b1, 1};
      rows[3] = '{LINK_UP, NO_ERR, 30, 12, 64'hFF00_0000_0000_0001, 1'b0, 1'b1, 2};
      rows[4] = '{LINK_DOWN, NO_ERR, 0, 0, 64'h0, 1'b0, 1'b1, 2};
      rows[5] = '{LINK_UP, NO_ERR, 20, 0, 64'h0, 1'b0, 1'b1, 2};
      rows[6] = '{LINK_UP, 4'd3, 0, 0, 64'h0, 1'b0, 1'b1, 2};
      rows[7] = '{LINK_UP, NO_ERR, 20, 0, 64'h0, 1'b0, 1'b1, 2};
      rows[8] = '{LINK_UP, NO_ERR, 30, 0, 64'h0, 1'b1, 1'b0, 0};
      rows[9] = '{LINK_UP, NO_ERR, 20, 3, 64'h1, 1'b0, 1'b1, 1};
   endtask

   // Counts cycles of phy_rst_n low, starting at the edge that began the reset
   task automatic measure_phy_reset();
      int n;
      n = 0;
      @(negedge FCLK);
      while (!phy_rst_n && n < 4 * RST_CYCLES) begin
         @(negedge FCLK);
         n++;
      end
      compare("phy_rst_n low cycles", 64'(n), 64'(RST_CYCLES));
   endtask

   task automatic apply_row(input int i);
      int   start;
      logic exp_led0;
      logic exp_led1;
      start        = rx_total;
      corrupt_at   = rx_total + rows[i].cidx;
      corrupt_mask = rows[i].mask;
      @(posedge FCLK);
      status <= rows[i].status;
      ecode  <= rows[i].ecode;
      if (rows[i].restart) begin
         restart <= 1'b1;
         @(posedge FCLK);
         restart <= 1'b0;
         measure_phy_reset();
         compare("data_err", 64'(data_err), 64'h0);
         compare("err_count", 64'(err_count), 64'h0);
      end
      if (rows[i].words > 0) begin
         while (rx_total - start < rows[i].words) @(negedge FCLK);
      end else begin
         // Traffic must stop while the link is down
         repeat (8) @(negedge FCLK);
         compare("tx_tvalid", 64'(tx_tvalid), 64'h0);
         compare("rx_tready", 64'(rx_tready), 64'h0);
      end
      exp_led0 = (rows[i].status == LINK_UP) && (rows[i].ecode == NO_ERR);
      exp_led1 = (rows[i].ecode == NO_ERR) && !rows[i].exp_err;
      compare("data_err", 64'(data_err), 64'(rows[i].exp_err));
      compare("err_count", 64'(err_count), 64'(rows[i].exp_cnt));
      compare("led", 64'(led), 64'({exp_led1, exp_led0}));
   endtask

   initial begin
      load_table();
      table_ready = 1'b1;
      repeat (3) @(posedge FCLK);
      ARSTn <= 1'b1;
      measure_phy_reset();
      for (int i = 0; i < NROWS; i++) begin
         apply_row(i);
      end
      $display("Errors: %0d of %0d checks", errors, checks);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

   // Limit grows with the words and resets in the table
   initial begin : watchdog
      int limit;
      wait (table_ready);
      limit = 100;
      for (int i = 0; i < NROWS; i++) begin
         limit += 8 * rows[i].words + 4 * RST_CYCLES;
      end
      repeat (limit) @(posedge FCLK);
      $display("Watchdog expired after %0d cycles, the table did not complete", limit);
      $display("Errors: %0d of %0d checks", errors, checks);
      $display("Checks failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the link exerciser testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
   --top-module link_exerciser_tb \
   -f verilog.f \
   -o link_exerciser_sim

./obj_dir/link_exerciser_sim 2>&1 | tee sim.log

if grep -qx "All checks passed" sim.log; then
   echo "Simulation result: PASS"
   exit 0
else
   echo "Simulation result: FAIL"
   exit 1
fi

// File: verilog.f
verilog/link_exerciser_pkg.sv
verilog/exer_ctrl_if.sv
verilog/reset_seq.sv
verilog/pattern_gen.sv
verilog/pattern_chk.sv
verilog/exer_ctrl.sv
verilog/link_exerciser_top.sv
dv/link_exerciser_chk.sv
dv/link_exerciser_tb.sv

// File: verilog/exer_ctrl.sv
/*
 Link exerciser controller: PHY reset, wait for link, run.
 restart is synchronous; only its rising edge is a request.
*/
`timescale 1ns/1ps
`default_nettype none

module exer_ctrl (
   input  wire logic                                   FCLK,
   input  wire logic                                   ARSTn,
   input  wire logic                                   restart,
   input  wire logic [link_exerciser_pkg::STATUS_W-1:0] status,
   input  wire logic [link_exerciser_pkg::ECODE_W-1:0]  ecode,
   input  wire logic                                   seq_done,
   output logic                                        seq_start,
   output logic                                        rx_tready,
   output logic      [1:0]                             led,
   exer_ctrl_if.ctrl                                   ctl
);

   link_exerciser_pkg::exer_state_t state;
   link_exerciser_pkg::exer_state_t state_nxt;

   logic restart_q;
   logic restart_rise;
   logic link_ok;
   logic running;

   always_ff @(posedge FCLK or negedge ARSTn) begin
      if (!ARSTn) begin
         restart_q <= 1'b0;
      end else begin
         restart_q <= restart;
      end
   end

   assign restart_rise = restart & ~restart_q;

   assign link_ok = (status == link_exerciser_pkg::STATUS_LINK_UP) &&
                    (ecode == link_exerciser_pkg::ECODE_NONE);

   always_comb begin
      state_nxt = state;
      case (state)
         link_exerciser_pkg::RESET: begin
            if (seq_done) state_nxt = link_exerciser_pkg::WAIT_LINK;
         end
         link_exerciser_pkg::WAIT_LINK: begin
            if (link_ok) state_nxt = link_exerciser_pkg::RUN;
         end
         link_exerciser_pkg::RUN: begin
            // Link loss pauses traffic, counters keep their values
            if (!link_ok) state_nxt = link_exerciser_pkg::WAIT_LINK;
         end
         default: state_nxt = link_exerciser_pkg::RESET;
      endcase
      // Restart wins over everything
      if (restart_rise) state_nxt = link_exerciser_pkg::RESET;
   end

   always_ff @(posedge FCLK or negedge ARSTn) begin
      if (!ARSTn) begin
         state <= link_exerciser_pkg::RESET;
      end else begin
         state <= state_nxt;
      end
   end

   assign running = (state == link_exerciser_pkg::RUN);

   // Same-cycle pulse so the sequencer drops phy_rst_n as RESET is entered
   assign seq_start = restart_rise;
   assign ctl.clear = restart_rise;
   assign ctl.run   = running;
   assign rx_tready = running;

   assign led[0] = running;
   assign led[1] = (ecode == link_exerciser_pkg::ECODE_NONE) & ~ctl.data_err;

endmodule

`default_nettype wire

// File: verilog/exer_ctrl_if.sv
/*
 Control and result bundle between the controller, generator and checker.
 The error counter must not be wider than the data word.
*/
`timescale 1ns/1ps
`default_nettype none

interface exer_ctrl_if #(
   parameter int DATA_W   = 64,
   parameter int ERRCNT_W = 16
);

   logic                run;
   logic                clear;
   logic                data_err;
   logic [ERRCNT_W-1:0] err_count;

   // More error bits than data bits can never be filled
   if (ERRCNT_W > DATA_W) begin : g_width_check
      $fatal(1, "exer_ctrl_if: ERRCNT_W exceeds DATA_W");
   end

   modport ctrl (output run, output clear, input data_err);
   modport gen  (input run, input clear);
   modport chk  (input run, input clear, output data_err, output err_count);

endinterface

`default_nettype wire

// File: verilog/link_exerciser_pkg.sv
/*
 Shared definitions for the link exerciser.
 Status and error code values follow the PHY's 4-bit STATUS/ECODE fields.
*/
`default_nettype none

package link_exerciser_pkg;

   // Controller states
   typedef enum logic [1:0] {
      RESET     = 2'd0,
      WAIT_LINK = 2'd1,
      RUN       = 2'd2
   } exer_state_t;

   // PHY status and error code fields
   localparam int STATUS_W = 4;
   localparam int ECODE_W  = 4;

   // Status reported once the link is trained and up
   localparam logic [STATUS_W-1:0] STATUS_LINK_UP = 4'd4;

   // Error code for a healthy link
   localparam logic [ECODE_W-1:0] ECODE_NONE = 4'd0;

   // Defaults for the top-level parameters
   localparam int DEF_DATA_W     = 64;
   localparam int DEF_RST_CYCLES = 16;
   localparam int DEF_ERRCNT_W   = 16;

endpackage

`default_nettype wire

// File: verilog/link_exerciser_top.sv
/*
 Link exerciser beside a PHY with a 64-bit valid/ready stream.
 RX never back-pressures while running; all ports are FCLK synchronous.
*/
`timescale 1ns/1ps
`default_nettype none

module link_exerciser_top #(
   parameter int DATA_W     = link_exerciser_pkg::DEF_DATA_W,
   parameter int RST_CYCLES = link_exerciser_pkg::DEF_RST_CYCLES,
   parameter int ERRCNT_W   = link_exerciser_pkg::DEF_ERRCNT_W
) (
   input  wire logic                                   FCLK,
   input  wire logic                                   ARSTn,
   input  wire logic                                   restart,
   output logic      [DATA_W-1:0]                      tx_tdata,
   output logic                                        tx_tvalid,
   input  wire logic                                   tx_tready,
   input  wire logic [DATA_W-1:0]                      rx_tdata,
   input  wire logic                                   rx_tvalid,
   output logic                                        rx_tready,
   input  wire logic [link_exerciser_pkg::STATUS_W-1:0] status,
   input  wire logic [link_exerciser_pkg::ECODE_W-1:0]  ecode,
   output logic                                        phy_rst_n,
   output logic                                        data_err,
   output logic      [ERRCNT_W-1:0]                    err_count,
   output logic      [1:0]                             led
);

   logic seq_start;
   logic seq_done;

   exer_ctrl_if #(
      .DATA_W  (DATA_W),
      .ERRCNT_W(ERRCNT_W)
   ) ctl_if ();

   exer_ctrl exer_ctrl_i (
      .FCLK     (FCLK),
      .ARSTn    (ARSTn),
      .restart  (restart),
      .status   (status),
      .ecode    (ecode),
      .seq_done (seq_done),
      .seq_start(seq_start),
      .rx_tready(rx_tready),
      .led      (led),
      .ctl      (ctl_if.ctrl)
   );

   reset_seq #(
      .RST_CYCLES(RST_CYCLES)
   ) reset_seq_i (
      .FCLK     (FCLK),
      .ARSTn    (ARSTn),
      .seq_start(seq_start),
      .seq_done (seq_done),
      .phy_rst_n(phy_rst_n)
   );

   pattern_gen #(
      .DATA_W(DATA_W)
   ) pattern_gen_i (
      .FCLK     (FCLK),
      .ARSTn    (ARSTn),
      .gen      (ctl_if.gen),
      .tx_tdata (tx_tdata),
      .tx_tready(tx_tready),
      .tx_tvalid(tx_tvalid)
   );

   pattern_chk #(
      .DATA_W  (DATA_W),
      .ERRCNT_W(ERRCNT_W)
   ) pattern_chk_i (
      .FCLK     (FCLK),
      .ARSTn    (ARSTn),
      .chk      (ctl_if.chk),
      .rx_tdata (rx_tdata),
      .rx_tvalid(rx_tvalid),
      .rx_tready(rx_tready)
   );

   assign data_err  = ctl_if.data_err;
   assign err_count = ctl_if.err_count;

endmodule

`default_nettype wire

// File: verilog/pattern_chk.sv
/*
 RX pattern checker. The reference advances on every accepted word, so
 one bad word costs one error. The count saturates at its maximum.
*/
`timescale 1ns/1ps
`default_nettype none

module pattern_chk #(
   parameter int DATA_W   = 64,
   parameter int ERRCNT_W = 16
) (
   input  wire logic              FCLK,
   input  wire logic              ARSTn,
   exer_ctrl_if.chk               chk,
   input  wire logic [DATA_W-1:0] rx_tdata,
   input  wire logic              rx_tvalid,
   input  wire logic              rx_tready
);

   logic [DATA_W-1:0]   ref_word;
   logic                err_flag;
   logic [ERRCNT_W-1:0] err_cnt;
   logic                accept;
   logic                mismatch;

   // Words only count while the controller is running
   assign accept   = rx_tvalid & rx_tready & chk.run;
   assign mismatch = accept & (rx_tdata != ref_word);

   // Reference follows its own sequence, not the received data
   always_ff @(posedge FCLK or negedge ARSTn) begin
      if (!ARSTn) begin
         ref_word <= '0;
      end else if (chk.clear) begin
         ref_word <= '0;
      end else if (accept) begin
         ref_word <= ref_word + DATA_W'(1);
      end
   end

   // Sticky flag and saturating count
   always_ff @(posedge FCLK or negedge ARSTn) begin
      if (!ARSTn) begin
         err_flag <= 1'b0;
         err_cnt  <= '0;
      end else if (chk.clear) begin
         err_flag <= 1'b0;
         err_cnt  <= '0;
      end else if (mismatch) begin
         err_flag <= 1'b1;
         if (err_cnt != {ERRCNT_W{1'b1}}) begin
            err_cnt <= err_cnt + ERRCNT_W'(1);
         end
      end
   end

   assign chk.data_err  = err_flag;
   assign chk.err_count = err_cnt;

endmodule

`default_nettype wire

// File: verilog/pattern_gen.sv
/*
 TX counter pattern source. The first word after clear is 0.
 Data holds while tx_tvalid is high and tx_tready is low.
*/
`timescale 1ns/1ps
`default_nettype none

module pattern_gen #(
   parameter int DATA_W = 64
) (
   input  wire logic              FCLK,
   input  wire logic              ARSTn,
   exer_ctrl_if.gen               gen,
   output logic      [DATA_W-1:0] tx_tdata,
   input  wire logic              tx_tready,
   output logic                   tx_tvalid
);

   logic [DATA_W-1:0] word_cnt;
   logic              valid_q;
   logic              accept;

   assign accept = valid_q & tx_tready;

   // Valid trails run by one cycle and drops at once on clear
   always_ff @(posedge FCLK or negedge ARSTn) begin
      if (!ARSTn) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= gen.run & ~gen.clear;
      end
   end

   // Advance only on an accepted word
   always_ff @(posedge FCLK or negedge ARSTn) begin
      if (!ARSTn) begin
         word_cnt <= '0;
      end else if (gen.clear) begin
         word_cnt <= '0;
      end else if (accept) begin
         word_cnt <= word_cnt + DATA_W'(1);
      end
   end

   assign tx_tdata  = word_cnt;
   assign tx_tvalid = valid_q;

endmodule

`default_nettype wire

// File: verilog/reset_seq.sv
/*
 PHY reset sequencer. phy_rst_n is held low for RST_CYCLES edges after
 ARSTn release or after seq_start, then rises together with seq_done.
*/
`timescale 1ns/1ps
`default_nettype none

module reset_seq #(
   parameter int RST_CYCLES = 16
) (
   input  wire logic FCLK,
   input  wire logic ARSTn,
   input  wire logic seq_start,
   output logic      seq_done,
   output logic      phy_rst_n
);

   localparam int CNT_W = (RST_CYCLES > 1) ? $clog2(RST_CYCLES) : 1;

   logic [CNT_W-1:0] cnt;
   logic             done;

   always_ff @(posedge FCLK or negedge ARSTn) begin
      if (!ARSTn) begin
         cnt  <= '0;
         done <= 1'b0;
      end else if (seq_start) begin
         // Restart the whole reset window
         cnt  <= '0;
         done <= 1'b0;
      end else if (!done) begin
         if (cnt == CNT_W'(RST_CYCLES - 1)) begin
            done <= 1'b1;
         end else begin
            cnt <= cnt + CNT_W'(1);
         end
      end
   end

   // PHY leaves reset at the same edge the sequence completes
   assign seq_done  = done;
   assign phy_rst_n = done;

endmodule

`default_nettype wire
